//--- design/lsu_fwd_cfg.svh
//********************
// lsu forwarding configuration
// widths of the data path and depth of the store pipe
//********************
`ifndef LSU_FWD_CFG_SVH
`define LSU_FWD_CFG_SVH

//********************
// data path
//********************
`define LSU_DATA_W 32      // bits per word
`define LSU_BYTES 4        // byte lanes per word

//********************
// addressing
//********************
`define LSU_ADDR_W 32      // byte address width

//********************
// store pipe
//********************
// older stages dc3, dc4 and dc5 compared against the dc2 load
`define LSU_STORE_DEPTH 3

`endif

//--- design/lsu_fwd_pkg.sv
//********************
// lsu forwarding types
// access size encoding and the decoded store entry
//********************
`include "lsu_fwd_cfg.svh"

package lsu_fwd_pkg;

  // byte offset bits inside a word
  localparam int OFS_W = $clog2(`LSU_BYTES);

  // word address width without the byte offset
  localparam int WORD_ADDR_W = `LSU_ADDR_W - OFS_W;

  //********************
  // access size
  //********************
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10   // 2'b11 unused
  } lsu_size_e;

  //********************
  // decoded access
  //********************
  // an access spans at most two words, lo and hi
  // hi word is always lo + 1, even when hi enables are all zero
  typedef struct packed {
    logic                   valid;
    logic [WORD_ADDR_W-1:0] lo_addr;   // word holding the first byte
    logic [WORD_ADDR_W-1:0] hi_addr;   // next word
    logic [`LSU_BYTES-1:0]  lo_be;     // lanes touched in lo word
    logic [`LSU_BYTES-1:0]  hi_be;     // lanes touched in hi word
    logic [`LSU_DATA_W-1:0] lo_data;   // store bytes in lo lanes
    logic [`LSU_DATA_W-1:0] hi_data;   // store bytes in hi lanes
  } lsu_store_entry_t;

endpackage

//--- design/lsu_fwd_decode.sv
//********************
// lsu request decode
// splits a raw request into lo/hi word addresses, enables and data
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module lsu_fwd_decode (
  input  logic                         req_valid,
  input  logic                         req_store,
  input  lsu_fwd_pkg::lsu_size_e       req_size,
  input  logic [`LSU_ADDR_W-1:0]       req_addr,
  input  logic [`LSU_DATA_W-1:0]       req_wdata,
  output lsu_fwd_pkg::lsu_store_entry_t st_entry,
  output lsu_fwd_pkg::lsu_store_entry_t ld_entry
);

  localparam int OFS_W = lsu_fwd_pkg::OFS_W;
  localparam int WA_W  = lsu_fwd_pkg::WORD_ADDR_W;

  logic [`LSU_BYTES-1:0]    size_mask;
  logic [2*`LSU_BYTES-1:0]  be_ext;     // enables over the 8 byte lo/hi window
  logic [2*`LSU_DATA_W-1:0] data_ext;   // data over the same window
  logic [OFS_W-1:0]         ofs;
  logic [WA_W-1:0]          word_lo;

  assign ofs     = req_addr[OFS_W-1:0];
  assign word_lo = req_addr[`LSU_ADDR_W-1:OFS_W];

  always_comb begin
    case (req_size)
      lsu_fwd_pkg::LSU_SIZE_BYTE: size_mask = `LSU_BYTES'(4'b0001);
      lsu_fwd_pkg::LSU_SIZE_HALF: size_mask = `LSU_BYTES'(4'b0011);
      lsu_fwd_pkg::LSU_SIZE_WORD: size_mask = `LSU_BYTES'(4'b1111);
      default:                    size_mask = '0;
    endcase
  end

  // move the access up to its byte offset, spilling into the hi word
  assign be_ext   = {{`LSU_BYTES{1'b0}}, size_mask} << ofs;
  assign data_ext = {{`LSU_DATA_W{1'b0}}, req_wdata} << {ofs, 3'b000};

  //********************
  // store and load views
  //********************
  always_comb begin
    st_entry.valid   = req_valid & req_store;
    st_entry.lo_addr = word_lo;
    st_entry.hi_addr = word_lo + WA_W'(1);   // wraps at the top of memory
    st_entry.lo_be   = be_ext[`LSU_BYTES-1:0];
    st_entry.hi_be   = be_ext[2*`LSU_BYTES-1:`LSU_BYTES];
    st_entry.lo_data = data_ext[`LSU_DATA_W-1:0];
    st_entry.hi_data = data_ext[2*`LSU_DATA_W-1:`LSU_DATA_W];

    // load sees the same window, only the valid bit differs
    ld_entry         = st_entry;
    ld_entry.valid   = req_valid & ~req_store;
  end

  // the spare size code would give an access with no lanes at all
  always_comb begin
    if (req_valid == 1'b1) begin
      assert (req_size != lsu_fwd_pkg::lsu_size_e'(2'b11))
        else $error("request with unused size code");
    end
  end

endmodule

//--- design/lsu_store_pipe.sv
//********************
// lsu store pipe
// carries decoded stores from dc2 through dc3, dc4 and dc5
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module lsu_store_pipe (
  input  logic                          clk,
  input  logic                          rst,
  input  lsu_fwd_pkg::lsu_store_entry_t st_entry,    // dc2 store
  output lsu_fwd_pkg::lsu_store_entry_t stage_dc3,
  output lsu_fwd_pkg::lsu_store_entry_t stage_dc4,
  output lsu_fwd_pkg::lsu_store_entry_t stage_dc5
);

  localparam int DEPTH = `LSU_STORE_DEPTH;

  // index 0 is dc3, the youngest stored entry
  lsu_fwd_pkg::lsu_store_entry_t pipe_q [DEPTH];

  //********************
  // shift register
  //********************
  always_ff @(posedge clk) begin
    pipe_q[0] <= st_entry;   // empty cycle brings in valid = 0
    for (int s = 1; s < DEPTH; s++) begin
      pipe_q[s] <= pipe_q[s-1];
    end
    if (rst) begin
      for (int s = 0; s < DEPTH; s++) begin
        pipe_q[s].valid <= 1'b0;   // payload left as is
      end
    end
  end

  assign stage_dc3 = pipe_q[0];
  assign stage_dc4 = pipe_q[1];
  assign stage_dc5 = pipe_q[2];

  // a store strobed in dc2 must arrive in dc3 with some lane to forward
  assert property (@(posedge clk) disable iff (rst)
    st_entry.valid |=> ((|stage_dc3.lo_be) || (|stage_dc3.hi_be)))
    else $error("store entered dc3 without byte enables");

endmodule

//--- design/lsu_fwd_match.sv
//********************
// lsu forwarding match
// per byte compare of the dc2 load against dc3..dc5 stores,
// youngest store wins each lane
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module lsu_fwd_match (
  input  lsu_fwd_pkg::lsu_store_entry_t ld_entry,
  input  lsu_fwd_pkg::lsu_store_entry_t stage_dc3,
  input  lsu_fwd_pkg::lsu_store_entry_t stage_dc4,
  input  lsu_fwd_pkg::lsu_store_entry_t stage_dc5,
  output logic [`LSU_DATA_W-1:0]        fwd_lo,   // forwarded lo word bytes
  output logic [`LSU_DATA_W-1:0]        fwd_hi,   // forwarded hi word bytes
  output logic [`LSU_BYTES-1:0]         hit_lo,   // lo lanes supplied
  output logic [`LSU_BYTES-1:0]         hit_hi    // hi lanes supplied
);

  localparam int NB    = `LSU_BYTES;
  localparam int DEPTH = `LSU_STORE_DEPTH;

  // stage 0 is dc3, youngest
  lsu_fwd_pkg::lsu_store_entry_t stage [DEPTH];

  logic [NB-1:0]          st_hit_lo  [DEPTH];
  logic [NB-1:0]          st_hit_hi  [DEPTH];
  logic [`LSU_DATA_W-1:0] st_data_lo [DEPTH];
  logic [`LSU_DATA_W-1:0] st_data_hi [DEPTH];

  assign stage[0] = stage_dc3;
  assign stage[1] = stage_dc4;
  assign stage[2] = stage_dc5;

  //********************
  // per stage compare
  //********************
  for (genvar s = 0; s < DEPTH; s++) begin : g_stage
    logic act;
    logic lo_in_lo, hi_in_lo;   // store lo/hi word equals load lo word
    logic lo_in_hi, hi_in_hi;   // store lo/hi word equals load hi word

    assign act      = stage[s].valid & ld_entry.valid;
    assign lo_in_lo = act & (stage[s].lo_addr == ld_entry.lo_addr);
    assign hi_in_lo = act & (stage[s].hi_addr == ld_entry.lo_addr);
    assign lo_in_hi = act & (stage[s].lo_addr == ld_entry.hi_addr);
    assign hi_in_hi = act & (stage[s].hi_addr == ld_entry.hi_addr);

    for (genvar i = 0; i < NB; i++) begin : g_lane
      logic use_hi_lo, use_hi_hi;

      assign use_hi_lo = hi_in_lo & stage[s].hi_be[i];
      assign use_hi_hi = hi_in_hi & stage[s].hi_be[i];

      assign st_hit_lo[s][i] = ld_entry.lo_be[i] &
                               ((lo_in_lo & stage[s].lo_be[i]) | use_hi_lo);
      assign st_hit_hi[s][i] = ld_entry.hi_be[i] &
                               ((lo_in_hi & stage[s].lo_be[i]) | use_hi_hi);

      // lo and hi of one store never name the same word, so one side at most
      assign st_data_lo[s][8*i +: 8] = use_hi_lo ? stage[s].hi_data[8*i +: 8]
                                                 : stage[s].lo_data[8*i +: 8];
      assign st_data_hi[s][8*i +: 8] = use_hi_hi ? stage[s].hi_data[8*i +: 8]
                                                 : stage[s].lo_data[8*i +: 8];
    end
  end

  //********************
  // priority select
  //********************
  // walk oldest to youngest so a younger hit overwrites the lane
  always_comb begin
    fwd_lo = '0;
    fwd_hi = '0;
    hit_lo = '0;
    hit_hi = '0;
    for (int s = DEPTH-1; s >= 0; s--) begin
      for (int i = 0; i < NB; i++) begin
        if (st_hit_lo[s][i]) begin
          fwd_lo[8*i +: 8] = st_data_lo[s][8*i +: 8];
          hit_lo[i]        = 1'b1;
        end
        if (st_hit_hi[s][i]) begin
          fwd_hi[8*i +: 8] = st_data_hi[s][8*i +: 8];
          hit_hi[i]        = 1'b1;
        end
      end
    end
  end

endmodule

//--- design/lsu_fwd_result.sv
//********************
// lsu load result
// hit flags, realigned forward data, one cycle later
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module lsu_fwd_result (
  input  logic                          clk,
  input  logic                          rst,
  input  lsu_fwd_pkg::lsu_store_entry_t ld_entry,
  input  logic [`LSU_ADDR_W-1:0]        req_addr,
  input  logic                          req_side_effect,
  input  logic [`LSU_DATA_W-1:0]        fwd_lo,
  input  logic [`LSU_DATA_W-1:0]        fwd_hi,
  input  logic [`LSU_BYTES-1:0]         hit_lo,
  input  logic [`LSU_BYTES-1:0]         hit_hi,
  input  logic [`LSU_DATA_W-1:0]        bus_rdata,   // read data of the reporting load
  output logic                          ld_valid,
  output logic                          ld_hit_any,
  output logic                          ld_full_hit,
  output logic [`LSU_DATA_W-1:0]        ld_data
);

  localparam int OFS_W = lsu_fwd_pkg::OFS_W;

  logic                     full_lo, full_hi;
  logic                     hit_any_d, full_hit_d;
  logic [2*`LSU_DATA_W-1:0] fwd_shift;
  logic [`LSU_DATA_W-1:0]   fwd_q;

  // every enabled lane supplied by some store
  assign full_lo    = &(hit_lo | ~ld_entry.lo_be);
  assign full_hi    = &(hit_hi | ~ld_entry.hi_be);
  assign hit_any_d  = (|hit_lo) | (|hit_hi);
  assign full_hit_d = full_lo & full_hi & ld_entry.valid & ~req_side_effect;

  // bring the first load byte back to lane 0
  assign fwd_shift = {fwd_hi, fwd_lo} >> {req_addr[OFS_W-1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_valid    <= 1'b0;
      ld_hit_any  <= 1'b0;
      ld_full_hit <= 1'b0;
    end else begin
      ld_valid    <= ld_entry.valid;
      ld_hit_any  <= hit_any_d;
      ld_full_hit <= full_hit_d;
    end
  end

  always_ff @(posedge clk) begin
    fwd_q <= fwd_shift[`LSU_DATA_W-1:0];
  end

  assign ld_data = ld_full_hit ? fwd_q : bus_rdata;   // partial hit goes to the bus

  // a full hit is only ever reported for a load that forwarded something
  assert property (@(posedge clk) disable iff (rst)
    ld_full_hit |-> (ld_valid && ld_hit_any))
    else $error("full hit without a forwarded byte");

endmodule

//--- design/lsu_fwd_top.sv
//********************
// lsu store to load forwarding
// decode, store pipe, match and load result
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module lsu_fwd_top (
  input  logic                    clk,
  input  logic                    rst,

  // dc2 request, one per cycle at most
  input  logic                    req_valid,
  input  logic                    req_store,
  input  lsu_fwd_pkg::lsu_size_e  req_size,
  input  logic [`LSU_ADDR_W-1:0]  req_addr,
  input  logic [`LSU_DATA_W-1:0]  req_wdata,
  input  logic                    req_side_effect,

  input  logic [`LSU_DATA_W-1:0]  bus_rdata,

  // load result, cycle after the strobe
  output logic                    ld_valid,
  output logic                    ld_hit_any,
  output logic                    ld_full_hit,
  output logic [`LSU_DATA_W-1:0]  ld_data
);

  lsu_fwd_pkg::lsu_store_entry_t st_entry, ld_entry;
  lsu_fwd_pkg::lsu_store_entry_t stage_dc3, stage_dc4, stage_dc5;

  logic [`LSU_DATA_W-1:0] fwd_lo, fwd_hi;
  logic [`LSU_BYTES-1:0]  hit_lo, hit_hi;

  lsu_fwd_decode u_decode (
    .req_valid (req_valid),
    .req_store (req_store),
    .req_size  (req_size),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .st_entry  (st_entry),
    .ld_entry  (ld_entry)
  );

  lsu_store_pipe u_store_pipe (
    .clk       (clk),
    .rst       (rst),
    .st_entry  (st_entry),
    .stage_dc3 (stage_dc3),
    .stage_dc4 (stage_dc4),
    .stage_dc5 (stage_dc5)
  );

  lsu_fwd_match u_match (
    .ld_entry  (ld_entry),
    .stage_dc3 (stage_dc3),
    .stage_dc4 (stage_dc4),
    .stage_dc5 (stage_dc5),
    .fwd_lo    (fwd_lo),
    .fwd_hi    (fwd_hi),
    .hit_lo    (hit_lo),
    .hit_hi    (hit_hi)
  );

  lsu_fwd_result u_result (
    .clk             (clk),
    .rst             (rst),
    .ld_entry        (ld_entry),
    .req_addr        (req_addr),
    .req_side_effect (req_side_effect),
    .fwd_lo          (fwd_lo),
    .fwd_hi          (fwd_hi),
    .hit_lo          (hit_lo),
    .hit_hi          (hit_hi),
    .bus_rdata       (bus_rdata),
    .ld_valid        (ld_valid),
    .ld_hit_any      (ld_hit_any),
    .ld_full_hit     (ld_full_hit),
    .ld_data         (ld_data)
  );

endmodule

//--- tests/tb_lsu_fwd.sv
//********************
// testbench for lsu store to load forwarding
// random loads and stores in a 16 byte window, byte level reference
//********************
`timescale 1ns/10ps
`include "lsu_fwd_cfg.svh"

module tb_lsu_fwd;

  localparam logic [31:0] SEED            = 32'hd62e3513;
  localparam int          RST_CYCLES      = 8;
  localparam int          DIRECTED_CYCLES = 64;     // upper bound of the directed part
  localparam int          RANDOM_CYCLES   = 2000;
  localparam int          TIMEOUT_CYCLES  = RST_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
  localparam int          NB              = `LSU_BYTES;
  localparam int          DEPTH           = `LSU_STORE_DEPTH;
  localparam logic [`LSU_ADDR_W-1:0] BASE_ADDR = 32'h0000_2a40;

  typedef struct packed {
    logic                   hit_any;
    logic                   full_hit;
    logic [`LSU_DATA_W-1:0] data;     // forwarded bytes from lane 0 up
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   req_valid;
  logic                   req_store;
  lsu_fwd_pkg::lsu_size_e req_size;
  logic [`LSU_ADDR_W-1:0] req_addr;
  logic [`LSU_DATA_W-1:0] req_wdata;
  logic                   req_side_effect;
  logic [`LSU_DATA_W-1:0] bus_rdata;
  logic                   ld_valid;
  logic                   ld_hit_any;
  logic                   ld_full_hit;
  logic [`LSU_DATA_W-1:0] ld_data;

  // store history with index 0 the store strobed one cycle back
  logic        hist_valid [DEPTH];
  logic [31:0] hist_addr  [DEPTH];
  logic [31:0] hist_n     [DEPTH];
  logic [31:0] hist_data  [DEPTH];

  logic        pend_valid, cur_valid;   // load strobed now / reporting now
  expect_t     pend_exp, cur_exp;
  logic [31:0] rdata_drv;
  logic [31:0] rng;
  int          cycle_count;
  int          n_loads, n_full, n_partial, n_cross;

  lsu_fwd_top u_lsu_fwd_top (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (req_valid),
    .req_store       (req_store),
    .req_size        (req_size),
    .req_addr        (req_addr),
    .req_wdata       (req_wdata),
    .req_side_effect (req_side_effect),
    .bus_rdata       (bus_rdata),
    .ld_valid        (ld_valid),
    .ld_hit_any      (ld_hit_any),
    .ld_full_hit     (ld_full_hit),
    .ld_data         (ld_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  //********************
  // helpers
  //********************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] size_bytes(input logic [1:0] sz);
    case (sz)
      2'b00:   return 32'd1;
      2'b01:   return 32'd2;
      default: return 32'd4;
    endcase
  endfunction

  // youngest store covering a byte supplies it
  // bytes above the access size stay zero
  function automatic expect_t ref_result(input logic [31:0] addr, input logic [1:0] sz,
                                         input logic se);
    expect_t     r;
    logic [31:0] n, ba, off;
    logic        found, all_found;
    int          k, s;
    r         = '0;
    n         = size_bytes(sz);
    all_found = 1'b1;
    for (k = 0; k < NB; k++) begin
      if (32'(k) < n) begin
        ba    = addr + 32'(k);
        found = 1'b0;
        for (s = 0; s < DEPTH; s++) begin
          off = ba - hist_addr[s];
          if (!found && hist_valid[s] && off < hist_n[s]) begin
            r.data[8*k +: 8] = hist_data[s][8*off +: 8];
            found            = 1'b1;
          end
        end
        if (found) r.hit_any = 1'b1;
        else all_found = 1'b0;
      end
    end
    r.full_hit = all_found & ~se;
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
    end
  endtask

  //********************
  // stimulus
  //********************
  task automatic do_cycle(input logic v, input logic st, input logic [1:0] sz,
                          input logic [31:0] addr, input logic [31:0] wdata, input logic se);
    int s;
    @(posedge clk);
    #1;
    cur_valid = pend_valid;   // last cycle's load reports now
    cur_exp   = pend_exp;
    rng       = xorshift32(rng);
    rdata_drv = rng;
    pend_valid = v & ~st;
    pend_exp   = '0;
    if (pend_valid) begin
      pend_exp = ref_result(addr, sz, se);
      n_loads++;
      if (pend_exp.full_hit) n_full++;
      if (pend_exp.hit_any && !pend_exp.full_hit) n_partial++;
      if ({30'b0, addr[1:0]} + size_bytes(sz) > 32'(NB) && pend_exp.hit_any) n_cross++;
    end
    for (s = DEPTH-1; s > 0; s--) begin
      hist_valid[s] = hist_valid[s-1];
      hist_addr[s]  = hist_addr[s-1];
      hist_n[s]     = hist_n[s-1];
      hist_data[s]  = hist_data[s-1];
    end
    hist_valid[0]   = v & st;
    hist_addr[0]    = addr;
    hist_n[0]       = size_bytes(sz);
    hist_data[0]    = wdata;
    req_valid       = v;
    req_store       = st;
    req_size        = lsu_fwd_pkg::lsu_size_e'(sz);
    req_addr        = addr;
    req_wdata       = wdata;
    req_side_effect = se;
    bus_rdata       = rdata_drv;
  endtask

  task automatic store_req(input logic [1:0] sz, input logic [3:0] ofs, input logic [31:0] w);
    do_cycle(1'b1, 1'b1, sz, BASE_ADDR + {28'h0, ofs}, w, 1'b0);
  endtask

  task automatic load_req(input logic [1:0] sz, input logic [3:0] ofs, input logic se);
    do_cycle(1'b1, 1'b0, sz, BASE_ADDR + {28'h0, ofs}, 32'h0, se);
  endtask

  task automatic idle_for(input int n);
    repeat (n) do_cycle(1'b0, 1'b0, 2'b00, 32'h0, 32'h0, 1'b0);
  endtask

  task automatic random_cycle();
    logic [31:0] ctl, w;
    logic [1:0]  sz;
    rng = xorshift32(rng);
    ctl = rng;
    rng = xorshift32(rng);
    w   = rng;
    sz  = ctl[5:4];
    if (sz == 2'b11) sz = 2'b10;   // spare code folded into word
    do_cycle(ctl[8:6] != 3'b000, ctl[9], sz, BASE_ADDR + {28'h0, ctl[3:0]}, w,
             ctl[12:10] == 3'b000);
  endtask

  //********************
  // compare and timeout
  //********************
  always @(negedge clk) begin
    if (!rst) begin
      check_value("ld_valid", 32'(ld_valid), 32'(cur_valid));
      if (cur_valid) begin
        check_value("ld_hit_any", 32'(ld_hit_any), 32'(cur_exp.hit_any));
        check_value("ld_full_hit", 32'(ld_full_hit), 32'(cur_exp.full_hit));
        if (cur_exp.full_hit) check_value("ld_data", ld_data, cur_exp.data);
        else check_value("ld_data", ld_data, rdata_drv);   // partial or none reads the bus
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) fail_run("timeout, the test did not finish in time");
  end

  initial begin
    req_valid = 1'b0;
    req_store = 1'b0;
    req_size  = lsu_fwd_pkg::LSU_SIZE_BYTE;
    req_addr  = '0;
    req_wdata = '0;
    req_side_effect = 1'b0;
    bus_rdata = '0;
    rdata_drv = '0;
    rng       = SEED;
    pend_valid = 1'b0;
    cur_valid  = 1'b0;
    pend_exp   = '0;
    cur_exp    = '0;
    cycle_count = 0;
    n_loads = 0;
    n_full = 0;
    n_partial = 0;
    n_cross = 0;
    for (int s = 0; s < DEPTH; s++) begin
      hist_valid[s] = 1'b0;
      hist_addr[s]  = '0;
      hist_n[s]     = '0;
      hist_data[s]  = '0;
    end
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;

    // stores alone keep ld_valid low
    idle_for(2);
    store_req(2'b10, 4'd0, 32'h1122_3344);
    store_req(2'b00, 4'd9, 32'h0000_00a5);
    idle_for(3);
    // aligned word right behind its store
    store_req(2'b10, 4'd0, 32'hcafe_0001);
    load_req(2'b10, 4'd0, 1'b0);
    // younger half wins lanes 1..2 over the older word
    store_req(2'b10, 4'd4, 32'haabb_ccdd);
    store_req(2'b01, 4'd5, 32'h0000_5566);
    load_req(2'b10, 4'd4, 1'b0);
    // misaligned word and half across a word boundary
    store_req(2'b10, 4'd8, 32'h0102_0304);
    store_req(2'b10, 4'd12, 32'h0506_0708);
    load_req(2'b10, 4'd10, 1'b0);
    store_req(2'b00, 4'd11, 32'h0000_00e1);
    store_req(2'b00, 4'd12, 32'h0000_00e2);
    load_req(2'b01, 4'd11, 1'b0);
    // partial overlap then a side effect load
    store_req(2'b01, 4'd2, 32'h0000_beef);
    load_req(2'b10, 4'd0, 1'b0);
    store_req(2'b10, 4'd0, 32'h5a5a_0ff0);
    load_req(2'b10, 4'd0, 1'b1);
    // dc5 still forwards and one cycle later the store is gone
    store_req(2'b10, 4'd4, 32'h7788_99aa);
    idle_for(2);
    load_req(2'b10, 4'd4, 1'b0);
    store_req(2'b10, 4'd8, 32'h3c3c_c3c3);
    idle_for(3);
    load_req(2'b10, 4'd8, 1'b0);
    idle_for(2);

    // counts below cover the random part on its own
    n_loads = 0;
    n_full = 0;
    n_partial = 0;
    n_cross = 0;
    repeat (RANDOM_CYCLES) random_cycle();
    idle_for(3);   // let the last load report

    if (n_full == 0 || n_partial == 0 || n_cross == 0) begin
      fail_run("random stimulus never hit a full, partial or boundary crossing forward");
    end else begin
      $display("%0d loads, %0d full hits, %0d partial", n_loads, n_full, n_partial);
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+design
design/lsu_fwd_pkg.sv
design/lsu_fwd_decode.sv
design/lsu_store_pipe.sv
design/lsu_fwd_match.sv
design/lsu_fwd_result.sv
design/lsu_fwd_top.sv
tests/tb_lsu_fwd.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the forwarding testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_lsu_fwd \
  --Mdir obj_dir -o tb_lsu_fwd > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_lsu_fwd > sim.log 2>&1 || echo "simulator exited with an error status"

grep -q ">>> FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log && echo "simulation passed" || { echo "no pass line in sim.log"; exit 1; }
